//--- design/req_pkg.sv
`default_nettype none

package req_pkg;

   ////////////////////////////////////////
   // Bus widths
   ////////////////////////////////////////
   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int BE_W       = 4;
   localparam int OUT_ADDR_W = 64;
   localparam int CFG_ADDR_W = 19;

   // Local register offsets carried on the outbound port
   localparam int LOC_ADDR_W = 12;

   // Doorbell fields from the submission manager
   localparam int Q_W       = 10;
   localparam int DB_DATA_W = 16;

   ////////////////////////////////////////
   // Init bus address map
   ////////////////////////////////////////
   localparam logic [ADDR_W-1:0] CFG_LIMIT   = 32'h0000_1000;
   localparam logic [ADDR_W-1:0] LOC_LIMIT   = 32'h0000_2000;
   localparam logic [ADDR_W-1:0] WIN_BASE    = 32'h0000_2000;
   localparam logic [ADDR_W-1:0] WIN_LIMIT   = 32'h0000_4000;
   localparam logic [ADDR_W-1:0] BAR0_OFFSET = 32'h0000_1010;
   localparam logic [ADDR_W-1:0] BAR1_OFFSET = 32'h0000_1014;

   ////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////
   typedef enum logic [3:0] {
      REQ_NONE   = 4'd0,
      REQ_MEM_WR = 4'd1,
      REQ_LOC_RD = 4'd8,
      REQ_LOC_WR = 4'd10
   } req_type_e;

   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_DB,
      ARB_INIT
   } arb_state_e;

   ////////////////////////////////////////
   // Bundles
   ////////////////////////////////////////
   typedef struct packed {
      logic              rden;
      logic              wren;
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   wbe;
      logic [ADDR_W-1:0] addr;
   } init_req_t;

   typedef struct packed {
      logic [DB_DATA_W-1:0] data;
      logic [Q_W-1:0]       q;
   } db_req_t;

   typedef struct packed {
      req_type_e             kind;
      logic                  wren;
      logic [DATA_W-1:0]     data;
      logic [BE_W-1:0]       be;
      logic [OUT_ADDR_W-1:0] addr;
   } out_req_t;

   typedef struct packed {
      logic [CFG_ADDR_W-1:0] addr;
      logic                  write;
      logic [DATA_W-1:0]     write_data;
      logic [BE_W-1:0]       byte_enable;
      logic                  read;
   } cfg_mgmt_t;

endpackage

`default_nettype wire

//--- design/init_bus_router.sv
`timescale 1ns/1ps
`default_nettype none

module init_bus_router (
   input  wire req_pkg::init_req_t init_req_i,
   input  wire                     init_valid_i,
   input  wire                     cfg_rdy_i,
   input  wire                     fwd_rdy_i,
   output logic                    cfg_valid_o,
   output logic                    fwd_valid_o,
   output req_pkg::req_type_e      fwd_kind_o,
   output logic                    init_rdy_o
);

   import req_pkg::*;

   logic is_cfg;
   logic is_loc;
   logic is_win;

   ////////////////////////////////////////
   // Region decode
   ////////////////////////////////////////
   assign is_cfg = (init_req_i.addr < CFG_LIMIT);
   assign is_loc = (init_req_i.addr >= CFG_LIMIT) && (init_req_i.addr < LOC_LIMIT);
   assign is_win = (init_req_i.addr >= WIN_BASE) && (init_req_i.addr < WIN_LIMIT);

   // Config space goes to the cfg port, everything else is forwarded
   assign cfg_valid_o = init_valid_i & is_cfg;
   assign fwd_valid_o = init_valid_i & ~is_cfg;

   // Ready comes back from whichever path owns the address
   assign init_rdy_o = is_cfg ? cfg_rdy_i : fwd_rdy_i;

   ////////////////////////////////////////
   // Outbound kind
   ////////////////////////////////////////
   always_comb begin
      fwd_kind_o = REQ_NONE;
      if (is_win && init_req_i.wren) begin
         fwd_kind_o = REQ_MEM_WR;
      end else if (is_loc && init_req_i.rden) begin
         fwd_kind_o = REQ_LOC_RD;
      end else if (is_loc && init_req_i.wren) begin
         fwd_kind_o = REQ_LOC_WR;
      end
      // Reads in the window and stray addresses stay REQ_NONE
   end

endmodule

`default_nettype wire

//--- design/cfg_mgmt_port.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_mgmt_port (
   input  wire                     clk,
   input  wire                     rstn,
   input  wire req_pkg::init_req_t init_req_i,
   input  wire                     valid_i,
   input  wire                     cfg_done_i,
   output logic                    rdy_o,
   output req_pkg::cfg_mgmt_t      cfg_o
);

   import req_pkg::*;

   logic                  write_q;
   logic                  read_q;
   logic [CFG_ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0]     wdata_q;
   logic [BE_W-1:0]       be_q;
   logic                  busy;
   logic                  accept;

   // One access at a time
   assign busy   = write_q | read_q;
   assign rdy_o  = ~busy;
   assign accept = valid_i & ~busy;

   ////////////////////////////////////////
   // Access strobes
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         write_q <= 1'b0;
         read_q  <= 1'b0;
      end else if (busy && cfg_done_i) begin
         // Strobes drop the cycle after done
         write_q <= 1'b0;
         read_q  <= 1'b0;
      end else if (accept) begin
         write_q <= init_req_i.wren;
         read_q  <= init_req_i.rden;
      end
   end

   ////////////////////////////////////////
   // Access payload
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (accept) begin
         // Byte address to dword address
         addr_q  <= init_req_i.addr[CFG_ADDR_W+1:2];
         wdata_q <= init_req_i.wdata;
         be_q    <= init_req_i.wbe;
      end
   end

   always_comb begin
      cfg_o.addr        = addr_q;
      cfg_o.write       = write_q;
      cfg_o.write_data  = wdata_q;
      cfg_o.byte_enable = be_q;
      cfg_o.read        = read_q;
   end

endmodule

`default_nettype wire

//--- design/req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module req_arbiter (
   input  wire  clk,
   input  wire  rstn,
   input  wire  db_valid_i,
   input  wire  init_valid_i,
   input  wire  out_rdy_i,
   output logic out_valid_o,
   output logic db_ack_o,
   output logic init_rdy_o,
   output logic sel_db_o,
   output logic init_accept_o
);

   import req_pkg::*;

   arb_state_e state;
   arb_state_e state_nxt;

   ////////////////////////////////////////
   // State register
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state <= ARB_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   ////////////////////////////////////////
   // Grant and handshake
   ////////////////////////////////////////
   always_comb begin
      state_nxt     = state;
      out_valid_o   = 1'b0;
      db_ack_o      = 1'b0;
      init_rdy_o    = 1'b0;
      init_accept_o = 1'b0;

      case (state)
         ARB_IDLE: begin
            // Doorbell has priority when both are pending
            if (db_valid_i) begin
               state_nxt = ARB_DB;
            end else if (init_valid_i) begin
               state_nxt = ARB_INIT;
            end
         end

         ARB_DB: begin
            out_valid_o = db_valid_i;
            db_ack_o    = out_rdy_i;
            if (db_valid_i && out_rdy_i) begin
               state_nxt = ARB_IDLE;
            end
         end

         ARB_INIT: begin
            out_valid_o   = init_valid_i;
            init_rdy_o    = out_rdy_i;
            init_accept_o = init_valid_i & out_rdy_i;
            if (init_valid_i && out_rdy_i) begin
               state_nxt = ARB_IDLE;
            end
         end

         default: begin
            state_nxt = ARB_IDLE;
         end
      endcase
   end

   // Builder mux follows the doorbell grant
   assign sel_db_o = (state == ARB_DB);

endmodule

`default_nettype wire

//--- design/tlp_req_builder.sv
`timescale 1ns/1ps
`default_nettype none

module tlp_req_builder (
   input  wire                     clk,
   input  wire                     rstn,
   input  wire                     sel_db_i,
   input  wire req_pkg::init_req_t init_req_i,
   input  wire req_pkg::req_type_e init_kind_i,
   input  wire                     init_accept_i,
   input  wire req_pkg::db_req_t   db_req_i,
   output req_pkg::out_req_t       out_req_o
);

   import req_pkg::*;

   logic [DATA_W-1:0] bar0;
   logic [DATA_W-1:0] bar1;
   logic              bar_wr;
   logic [ADDR_W-1:0] win_offset;

   ////////////////////////////////////////
   // Endpoint base address capture
   ////////////////////////////////////////
   assign bar_wr = init_accept_i & init_req_i.wren;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         bar0 <= '0;
         bar1 <= '0;
      end else if (bar_wr) begin
         if (init_req_i.addr == BAR0_OFFSET) begin
            bar0 <= init_req_i.wdata;
         end
         if (init_req_i.addr == BAR1_OFFSET) begin
            bar1 <= init_req_i.wdata;
         end
      end
   end

   // Window offset relative to the endpoint BAR
   assign win_offset = init_req_i.addr - WIN_BASE;

   ////////////////////////////////////////
   // Outbound request fields
   ////////////////////////////////////////
   always_comb begin
      if (sel_db_i) begin
         out_req_o.kind = REQ_MEM_WR;
         out_req_o.wren = 1'b1;
         out_req_o.data = {{(DATA_W-DB_DATA_W){1'b0}}, db_req_i.data};
         out_req_o.be   = {BE_W{1'b1}};
         // Doorbell register of queue q inside the controller BAR
         out_req_o.addr = {bar1, bar0[DATA_W-1:13], 1'b1, db_req_i.q, 2'b00};
      end else begin
         out_req_o.kind = init_kind_i;
         out_req_o.wren = init_req_i.wren;
         out_req_o.data = init_req_i.wdata;
         out_req_o.be   = init_req_i.wbe;
         case (init_kind_i)
            REQ_LOC_RD,
            REQ_LOC_WR: begin
               out_req_o.addr = {{(OUT_ADDR_W-LOC_ADDR_W){1'b0}},
                                 init_req_i.addr[LOC_ADDR_W-1:0]};
            end
            default: begin
               out_req_o.addr = {bar1, bar0 | win_offset};
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/req_top.sv
`timescale 1ns/1ps
`default_nettype none

module req_top (
   input  wire                     clk,
   input  wire                     rstn,

   // Init bus from the host
   input  wire req_pkg::init_req_t init_req_i,
   input  wire                     init_valid_i,
   output logic                    init_rdy_o,

   // Submission queue doorbells
   input  wire req_pkg::db_req_t   db_req_i,
   input  wire                     db_valid_i,
   output logic                    db_ack_o,

   // Outbound request port
   output req_pkg::out_req_t       out_req_o,
   output logic                    out_valid_o,
   input  wire                     out_rdy_i,

   // Configuration management
   output req_pkg::cfg_mgmt_t      cfg_o,
   input  wire                     cfg_done_i
);

   import req_pkg::*;

   logic      cfg_valid;
   logic      cfg_rdy;
   logic      init_fwd_valid;
   logic      init_fwd_rdy;
   req_type_e init_kind;
   logic      sel_db;
   logic      init_accept;

   ////////////////////////////////////////
   // Address split
   ////////////////////////////////////////
   init_bus_router u_init_bus_router (
      .init_req_i   (init_req_i),
      .init_valid_i (init_valid_i),
      .cfg_rdy_i    (cfg_rdy),
      .fwd_rdy_i    (init_fwd_rdy),
      .cfg_valid_o  (cfg_valid),
      .fwd_valid_o  (init_fwd_valid),
      .fwd_kind_o   (init_kind),
      .init_rdy_o   (init_rdy_o)
   );

   cfg_mgmt_port u_cfg_mgmt_port (
      .clk        (clk),
      .rstn       (rstn),
      .init_req_i (init_req_i),
      .valid_i    (cfg_valid),
      .cfg_done_i (cfg_done_i),
      .rdy_o      (cfg_rdy),
      .cfg_o      (cfg_o)
   );

   ////////////////////////////////////////
   // Outbound request path
   ////////////////////////////////////////
   req_arbiter u_req_arbiter (
      .clk           (clk),
      .rstn          (rstn),
      .db_valid_i    (db_valid_i),
      .init_valid_i  (init_fwd_valid),
      .out_rdy_i     (out_rdy_i),
      .out_valid_o   (out_valid_o),
      .db_ack_o      (db_ack_o),
      .init_rdy_o    (init_fwd_rdy),
      .sel_db_o      (sel_db),
      .init_accept_o (init_accept)
   );

   tlp_req_builder u_tlp_req_builder (
      .clk           (clk),
      .rstn          (rstn),
      .sel_db_i      (sel_db),
      .init_req_i    (init_req_i),
      .init_kind_i   (init_kind),
      .init_accept_i (init_accept),
      .db_req_i      (db_req_i),
      .out_req_o     (out_req_o)
   );

endmodule

`default_nettype wire

//--- include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// src bit 0 marks an init request, bit 1 a doorbell, both bits set for a race
typedef struct packed {
   logic [1:0]  src;
   logic        to_cfg;
   logic        rden;
   logic        wren;
   logic [31:0] addr;
   logic [31:0] wdata;
   logic [3:0]  wbe;
   logic [3:0]  exp_kind;
   logic [63:0] exp_addr;
   logic [9:0]  q;
   logic [15:0] db_data;
   logic [63:0] exp_db_addr;
} vec_t;

localparam int NUM_VECS = 16;

vec_t vecs [NUM_VECS];

// Init side: cfg path, rden, wren, addr, wdata, wbe, expected kind and address
// For cfg entries the expected address is the dword address
task automatic set_init(input int idx, input logic cfg, input logic rd, input logic wr,
                        input logic [31:0] addr, input logic [31:0] wdata,
                        input logic [3:0] be, input logic [3:0] kind, input logic [63:0] exp);
   vec_t v;
   v          = vecs[idx];
   v.src      = v.src | 2'b01;
   v.to_cfg   = cfg;
   v.rden     = rd;
   v.wren     = wr;
   v.addr     = addr;
   v.wdata    = wdata;
   v.wbe      = be;
   v.exp_kind = kind;
   v.exp_addr = exp;
   vecs[idx]  = v;
endtask

// Doorbell side: queue, pointer, expected address
task automatic set_db(input int idx, input logic [9:0] q, input logic [15:0] data,
                      input logic [63:0] exp);
   vec_t v;
   v             = vecs[idx];
   v.src         = v.src | 2'b10;
   v.q           = q;
   v.db_data     = data;
   v.exp_db_addr = exp;
   vecs[idx]     = v;
endtask

task automatic load_vectors;
   int i;
   for (i = 0; i < NUM_VECS; i++) begin
      vecs[i] = '0;
   end
   // Config accesses back to back
   set_init(0, 1, 0, 1, 32'h0000_0124, 32'hA5A5_0001, 4'hF, REQ_NONE, 64'h49);
   set_init(1, 1, 1, 0, 32'h0000_0FFC, 32'h0000_0000, 4'hF, REQ_NONE, 64'h3FF);
   set_init(2, 1, 0, 1, 32'h0000_0008, 32'h1234_5678, 4'h3, REQ_NONE, 64'h2);
   // Doorbell with BARs still zero
   set_db(3, 10'h005, 16'h0010, 64'h0000_0000_0000_1014);
   // BAR0 then BAR1
   set_init(4, 0, 0, 1, 32'h0000_1010, 32'hF7A0_0000, 4'hF, REQ_LOC_WR, 64'h010);
   set_init(5, 0, 0, 1, 32'h0000_1014, 32'h0000_0003, 4'hF, REQ_LOC_WR, 64'h014);
   set_db(6, 10'h3FF, 16'hBEEF, 64'h0000_0003_F7A0_1FFC);
   set_init(7, 0, 0, 1, 32'h0000_2040, 32'hCAFE_0001, 4'hF, REQ_MEM_WR, 64'h0000_0003_F7A0_0040);
   set_init(8, 0, 1, 0, 32'h0000_1ABC, 32'h0000_0000, 4'hF, REQ_LOC_RD, 64'hABC);
   // Doorbell and init valid together
   set_db(9, 10'h012, 16'h0042, 64'h0000_0003_F7A0_1048);
   set_init(9, 0, 0, 1, 32'h0000_3FFC, 32'h5555_AAAA, 4'hC, REQ_MEM_WR, 64'h0000_0003_F7A0_1FFC);
   set_db(10, 10'h200, 16'hFFFF, 64'h0000_0003_F7A0_1800);
   set_init(10, 0, 0, 1, 32'h0000_1100, 32'h0BAD_F00D, 4'h1, REQ_LOC_WR, 64'h100);
   // New BAR0 with bit 13 set
   set_init(11, 0, 0, 1, 32'h0000_1010, 32'h8000_2000, 4'hF, REQ_LOC_WR, 64'h010);
   set_db(12, 10'h001, 16'h0001, 64'h0000_0003_8000_3004);
   set_init(13, 0, 0, 1, 32'h0000_2004, 32'h0000_0077, 4'hF, REQ_MEM_WR, 64'h0000_0003_8000_2004);
   // Window read has no outbound kind
   set_init(14, 0, 1, 0, 32'h0000_2100, 32'h0000_0000, 4'hF, REQ_NONE, 64'h0000_0003_8000_2100);
   set_init(15, 1, 0, 1, 32'h0000_0800, 32'hDEAD_BEEF, 4'hF, REQ_NONE, 64'h200);
endtask

`endif

//--- verification/tb_req_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_req_top;

   import req_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int DRIVE_DLY    = 1;

   logic        clk;
   logic        rstn;
   init_req_t   init_req;
   logic        init_valid;
   logic        init_rdy;
   db_req_t     db_req;
   logic        db_valid;
   logic        db_ack;
   out_req_t    out_req;
   logic        out_valid;
   logic        out_rdy;
   cfg_mgmt_t   cfg;
   logic        cfg_done;

   integer      seed;
   logic [31:0] rnd_word;
   int          cycle_cnt;
   int          xfer_cnt;
   int          exp_xfers;
   int          vec_idx;
   logic        held;
   out_req_t    held_req;
   logic        cfg_open;

   `include "tb_vectors.svh"

   localparam int CYCLE_LIMIT = NUM_VECS * 40 + RESET_CYCLES;

   req_top u_req_top (
      .clk          (clk),
      .rstn         (rstn),
      .init_req_i   (init_req),
      .init_valid_i (init_valid),
      .init_rdy_o   (init_rdy),
      .db_req_i     (db_req),
      .db_valid_i   (db_valid),
      .db_ack_o     (db_ack),
      .out_req_o    (out_req),
      .out_valid_o  (out_valid),
      .out_rdy_i    (out_rdy),
      .cfg_o        (cfg),
      .cfg_done_i   (cfg_done)
   );

   always #50 clk = ~clk;

   task automatic check_val(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("TB FAILED");
         $fatal(1);
      end
   endtask

   ////////////////////////////////////////
   // Apply one table entry
   ////////////////////////////////////////
   task automatic run_vec(input vec_t v);
      logic init_pend;
      logic db_pend;
      init_pend  = v.src[0];
      db_pend    = v.src[1];
      init_req   = {v.rden, v.wren, v.wdata, v.wbe, v.addr};
      db_req     = {v.db_data, v.q};
      init_valid = init_pend;
      db_valid   = db_pend;
      while (init_pend || db_pend) begin
         @(negedge clk);
         // Second config request must wait for the open access
         if (init_pend && v.to_cfg && cfg_open) begin
            check_val("init_rdy_o", init_rdy, 1'b0);
         end
         if (db_pend && db_ack) begin
            check_val("out_valid_o", out_valid, 1'b1);
            check_val("out_req_o.kind", out_req.kind, REQ_MEM_WR);
            check_val("out_req_o.wren", out_req.wren, 1'b1);
            check_val("out_req_o.data", out_req.data, {16'h0, v.db_data});
            check_val("out_req_o.be", out_req.be, 4'hF);
            check_val("out_req_o.addr", out_req.addr, v.exp_db_addr);
            db_pend = 1'b0;
         end
         if (init_pend && init_rdy) begin
            // Doorbell wins a tie so it has already transferred
            check_val("db_valid_i at init_rdy_o", db_pend, 1'b0);
            if (!v.to_cfg) begin
               check_val("out_valid_o", out_valid, 1'b1);
               check_val("out_req_o.kind", out_req.kind, v.exp_kind);
               check_val("out_req_o.wren", out_req.wren, v.wren);
               check_val("out_req_o.data", out_req.data, v.wdata);
               check_val("out_req_o.be", out_req.be, v.wbe);
               check_val("out_req_o.addr", out_req.addr, v.exp_addr);
            end else begin
               cfg_open = 1'b1;
            end
            init_pend = 1'b0;
         end
         @(posedge clk);
         #DRIVE_DLY;
         init_valid = init_pend;
         db_valid   = db_pend;
      end
      if (v.to_cfg) begin
         // Strobe rose at the accepting edge
         @(negedge clk);
         check_val("cfg_o.write", cfg.write, v.wren);
         check_val("cfg_o.read", cfg.read, v.rden);
         check_val("cfg_o.addr", cfg.addr, v.exp_addr[18:0]);
         check_val("cfg_o.write_data", cfg.write_data, v.wdata);
         check_val("cfg_o.byte_enable", cfg.byte_enable, v.wbe);
         @(posedge clk);
         #DRIVE_DLY;
      end
   endtask

   // Random back-pressure on the outbound port
   always @(posedge clk) begin
      #DRIVE_DLY;
      rnd_word = $random(seed);
      out_rdy  = rnd_word[0];
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("Timeout: the table did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TB FAILED");
         $fatal(1);
      end
   end

   ////////////////////////////////////////
   // Outbound monitor
   ////////////////////////////////////////
   always @(negedge clk) begin
      if (rstn && out_valid) begin
         if (held) begin
            check_val("out_req_o held", out_req, held_req);
         end
         held_req = out_req;
         held     = !out_rdy;
         if (out_rdy) begin
            xfer_cnt = xfer_cnt + 1;
         end
      end else begin
         held = 1'b0;
      end
   end

   // Config block answers three cycles after each strobe rises
   initial begin
      cfg_done = 1'b0;
      forever begin
         @(negedge clk);
         if (rstn && (cfg.write || cfg.read)) begin
            repeat (3) @(posedge clk);
            #DRIVE_DLY;
            cfg_done = 1'b1;
            @(posedge clk);
            #DRIVE_DLY;
            cfg_done = 1'b0;
            cfg_open = 1'b0;
         end
      end
   end

   initial begin
      clk        = 1'b0;
      rstn       = 1'b0;
      init_req   = '0;
      init_valid = 1'b0;
      db_req     = '0;
      db_valid   = 1'b0;
      out_rdy    = 1'b0;
      seed       = 32'h6081_78f3;
      cycle_cnt  = 0;
      xfer_cnt   = 0;
      exp_xfers  = 0;
      held       = 1'b0;
      held_req   = '0;
      cfg_open   = 1'b0;
      load_vectors();
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      rstn = 1'b1;
      for (vec_idx = 0; vec_idx < NUM_VECS; vec_idx++) begin
         run_vec(vecs[vec_idx]);
         exp_xfers = exp_xfers + vecs[vec_idx].src[1];
         exp_xfers = exp_xfers + (vecs[vec_idx].src[0] && !vecs[vec_idx].to_cfg);
      end
      if (xfer_cnt == exp_xfers) begin
         $display("TB PASSED");
         $finish;
      end else begin
         check_val("outbound transfer count", xfer_cnt, exp_xfers);
      end
   end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
design/req_pkg.sv
design/init_bus_router.sv
design/cfg_mgmt_port.sv
design/req_arbiter.sv
design/tlp_req_builder.sv
design/req_top.sv
verification/tb_req_top.sv
